/* compile.f */
logic/cpu_pkg.sv
logic/dbus_pkg.sv
logic/load_store_unit.sv
logic/data_ram.sv
logic/dbus_subsystem.sv
test/dbus_subsystem_properties.sv
test/dbus_subsystem_tb.sv

/* logic/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] uint32_t;

	// Bit 3 set marks a store, bit 2 set marks an unsigned load
	typedef enum logic [3:0] {
		op_lb  = 4'h0,
		op_lh  = 4'h1,
		op_lw  = 4'h2,
		op_lbu = 4'h4,
		op_lhu = 4'h5,
		op_sb  = 4'h8,
		op_sh  = 4'h9,
		op_sw  = 4'ha
	} mem_op_t;

	function automatic logic is_load(mem_op_t op);
		case (op)
			op_lb, op_lh, op_lw, op_lbu, op_lhu: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic is_store(mem_op_t op);
		case (op)
			op_sb, op_sh, op_sw: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

/* logic/data_ram.sv */
module data_ram #(
	parameter int pipe_depth = 2,
	parameter int mem_size   = dbus_pkg::default_size
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  read,
	input  logic                  write,
	input  logic                  uncached_read,
	input  logic                  uncached_write,
	input  cpu_pkg::uint32_t      addr,
	input  dbus_pkg::byteenable_t byteenable,
	input  cpu_pkg::uint32_t      wrdata,
	output cpu_pkg::uint32_t      rddata,
	output cpu_pkg::uint32_t      uncached_rddata
);

	localparam int index_width = $clog2(mem_size);

	typedef struct packed {
		logic                  read;
		logic                  write;
		logic                  uncached_read;
		logic                  uncached_write;
		cpu_pkg::uint32_t      addr;
		dbus_pkg::byteenable_t byteenable;
		cpu_pkg::uint32_t      wrdata;
	} bus_req_t;

	cpu_pkg::uint32_t       mem [mem_size];
	bus_req_t               bus_in;
	bus_req_t               pipe;
	logic [index_width-1:0] index;
	cpu_pkg::uint32_t       word;
	cpu_pkg::uint32_t       merged;

	assign bus_in = '{read, write, uncached_read, uncached_write, addr, byteenable, wrdata};

	generate
		if (pipe_depth == 1) begin : g_pipe1
			assign pipe = bus_in;
		end else begin : g_pipe2
			bus_req_t stage_q [pipe_depth-1];

			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					for (int i = 0; i < pipe_depth - 1; i++) begin
						stage_q[i] <= '0;
					end
				end else begin
					stage_q[0] <= bus_in;
					for (int i = 1; i < pipe_depth - 1; i++) begin
						stage_q[i] <= stage_q[i-1];
					end
				end
			end

			assign pipe = stage_q[pipe_depth-2];
		end
	endgenerate

	assign index = pipe.addr[index_width+1:2]; // Segment bits are ignored so uncached aliases cached
	assign word  = mem[index];

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			merged[8*i +: 8] = pipe.byteenable[i] ? pipe.wrdata[8*i +: 8] : word[8*i +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst && (pipe.write || pipe.uncached_write)) begin
			mem[index] <= merged;
		end
	end

	assign rddata          = pipe.read ? word : 'x;
	assign uncached_rddata = pipe.uncached_read ? word : 'x;

endmodule

/* logic/dbus_pkg.sv */
package dbus_pkg;

	// One enable bit per byte lane, bit 0 is the lowest byte
	typedef logic [3:0] byteenable_t;

	// Address bits 31 to 29 of the uncached window
	localparam logic [2:0] uncached_seg = 3'b101;

	// RAM depth in words unless the top level says otherwise
	localparam int default_size = 8192;

endpackage

/* logic/dbus_subsystem.sv */
module dbus_subsystem #(
	parameter int pipe_depth = 2,
	parameter int mem_size   = 1024
)(
	input  logic             clk,
	input  logic             rst,
	input  logic             req_valid,
	input  cpu_pkg::mem_op_t req_op,
	input  cpu_pkg::uint32_t req_addr,
	input  cpu_pkg::uint32_t req_wdata,
	output logic             load_valid,
	output cpu_pkg::uint32_t load_data,
	output logic             misaligned
);

	logic                  dbus_read;
	logic                  dbus_write;
	logic                  dbus_uncached_read;
	logic                  dbus_uncached_write;
	cpu_pkg::uint32_t      dbus_addr;
	dbus_pkg::byteenable_t dbus_byteenable;
	cpu_pkg::uint32_t      dbus_wrdata;
	cpu_pkg::uint32_t      dbus_rddata;
	cpu_pkg::uint32_t      dbus_uncached_rddata;

	load_store_unit #(
		.pipe_depth (pipe_depth)
	) u_lsu (
		.clk                  (clk),
		.rst                  (rst),
		.req_valid            (req_valid),
		.req_op               (req_op),
		.req_addr             (req_addr),
		.req_wdata            (req_wdata),
		.dbus_rddata          (dbus_rddata),
		.dbus_uncached_rddata (dbus_uncached_rddata),
		.dbus_read            (dbus_read),
		.dbus_write           (dbus_write),
		.dbus_uncached_read   (dbus_uncached_read),
		.dbus_uncached_write  (dbus_uncached_write),
		.dbus_addr            (dbus_addr),
		.dbus_byteenable      (dbus_byteenable),
		.dbus_wrdata          (dbus_wrdata),
		.load_valid           (load_valid),
		.load_data            (load_data),
		.misaligned           (misaligned)
	);

	data_ram #(
		.pipe_depth (pipe_depth),
		.mem_size   (mem_size)
	) u_ram (
		.clk             (clk),
		.rst             (rst),
		.read            (dbus_read),
		.write           (dbus_write),
		.uncached_read   (dbus_uncached_read),
		.uncached_write  (dbus_uncached_write),
		.addr            (dbus_addr),
		.byteenable      (dbus_byteenable),
		.wrdata          (dbus_wrdata),
		.rddata          (dbus_rddata),
		.uncached_rddata (dbus_uncached_rddata)
	);

endmodule

/* logic/load_store_unit.sv */
module load_store_unit #(
	parameter int pipe_depth = 2
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_valid,
	input  cpu_pkg::mem_op_t      req_op,
	input  cpu_pkg::uint32_t      req_addr,
	input  cpu_pkg::uint32_t      req_wdata,
	input  cpu_pkg::uint32_t      dbus_rddata,
	input  cpu_pkg::uint32_t      dbus_uncached_rddata,
	output logic                  dbus_read,
	output logic                  dbus_write,
	output logic                  dbus_uncached_read,
	output logic                  dbus_uncached_write,
	output cpu_pkg::uint32_t      dbus_addr,
	output dbus_pkg::byteenable_t dbus_byteenable,
	output cpu_pkg::uint32_t      dbus_wrdata,
	output logic                  load_valid,
	output cpu_pkg::uint32_t      load_data,
	output logic                  misaligned
);

	typedef struct packed {
		logic             valid;
		logic             uncached;
		logic [1:0]       lsb;
		cpu_pkg::mem_op_t op;
	} load_tag_t;

	logic             is_load;
	logic             is_store;
	logic             uncached;
	logic             bad_align;
	logic             accept;
	load_tag_t        req_tag;
	load_tag_t        rsp_tag;
	cpu_pkg::uint32_t rd_word;
	cpu_pkg::uint32_t rd_shift;

	assign is_load  = cpu_pkg::is_load(req_op);
	assign is_store = cpu_pkg::is_store(req_op);
	assign uncached = req_addr[31:29] == dbus_pkg::uncached_seg;

	always_comb begin
		bad_align       = 1'b0;
		dbus_byteenable = 4'b0000;
		dbus_wrdata     = req_wdata;
		case (req_op)
			cpu_pkg::op_lb, cpu_pkg::op_lbu, cpu_pkg::op_sb: begin
				dbus_byteenable = 4'b0001 << req_addr[1:0];
				dbus_wrdata     = {4{req_wdata[7:0]}};
			end
			cpu_pkg::op_lh, cpu_pkg::op_lhu, cpu_pkg::op_sh: begin
				bad_align       = req_addr[0];
				dbus_byteenable = req_addr[1] ? 4'b1100 : 4'b0011;
				dbus_wrdata     = {2{req_wdata[15:0]}};
			end
			cpu_pkg::op_lw, cpu_pkg::op_sw: begin
				bad_align       = req_addr[1:0] != 2'b00;
				dbus_byteenable = 4'b1111;
			end
			default: ;
		endcase
	end

	assign accept     = req_valid && !bad_align && (is_load || is_store);
	assign misaligned = req_valid && bad_align; // Refused requests raise no strobe

	assign dbus_read           = accept && is_load && !uncached;
	assign dbus_uncached_read  = accept && is_load && uncached;
	assign dbus_write          = accept && is_store && !uncached;
	assign dbus_uncached_write = accept && is_store && uncached;
	assign dbus_addr           = req_addr;

	assign req_tag.valid    = accept && is_load;
	assign req_tag.uncached = uncached;
	assign req_tag.lsb      = req_addr[1:0];
	assign req_tag.op       = req_op;

	// The tag follows the load through the same number of stages as the RAM input
	generate
		if (pipe_depth == 1) begin : g_no_delay
			assign rsp_tag = req_tag;
		end else begin : g_delay
			load_tag_t tag_q [pipe_depth-1];

			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					for (int i = 0; i < pipe_depth - 1; i++) begin
						tag_q[i] <= '0;
					end
				end else begin
					tag_q[0] <= req_tag;
					for (int i = 1; i < pipe_depth - 1; i++) begin
						tag_q[i] <= tag_q[i-1];
					end
				end
			end

			assign rsp_tag = tag_q[pipe_depth-2];
		end
	endgenerate

	assign rd_word  = rsp_tag.uncached ? dbus_uncached_rddata : dbus_rddata;
	assign rd_shift = rd_word >> {rsp_tag.lsb, 3'b000}; // Addressed byte moves to lane 0

	always_comb begin
		case (rsp_tag.op)
			cpu_pkg::op_lb:  load_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
			cpu_pkg::op_lbu: load_data = {24'h000000, rd_shift[7:0]};
			cpu_pkg::op_lh:  load_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
			cpu_pkg::op_lhu: load_data = {16'h0000, rd_shift[15:0]};
			default:         load_data = rd_word;
		endcase
	end

	assign load_valid = rsp_tag.valid;

endmodule

/* test/dbus_golden.txt */
// Columns: tag op addr wdata expected_load expected_misaligned, one entry per line
// op: 0 lb 1 lh 2 lw 4 lbu 5 lhu 8 sb 9 sh a sw; tag 00 is a bubble and tag ff ends the stream
01 a 00000100 11223344 00000000 0
01 2 00000100 00000000 11223344 0
01 a 00000104 cafef00d 00000000 0
01 2 00000104 00000000 cafef00d 0
00 0 00000000 00000000 00000000 0
02 a 00000108 a1b2c3d4 00000000 0
02 8 00000109 abcdefee 00000000 0
02 9 0000010a 98765566 00000000 0
02 2 00000108 00000000 5566eed4 0
02 8 0000010b 00000077 00000000 0
02 9 00000108 00001234 00000000 0
02 2 00000108 00000000 77661234 0
03 a 0000010c 80ff7f01 00000000 0
03 0 0000010c 00000000 00000001 0
03 0 0000010d 00000000 0000007f 0
03 0 0000010e 00000000 ffffffff 0
03 0 0000010f 00000000 ffffff80 0
03 4 0000010c 00000000 00000001 0
03 4 0000010d 00000000 0000007f 0
03 4 0000010e 00000000 000000ff 0
03 4 0000010f 00000000 00000080 0
03 1 0000010c 00000000 00007f01 0
03 1 0000010e 00000000 ffff80ff 0
03 5 0000010c 00000000 00007f01 0
03 5 0000010e 00000000 000080ff 0
00 0 00000000 00000000 00000000 0
04 a 00000110 deadbeef 00000000 0
04 2 a0000110 00000000 deadbeef 0
04 a a0000114 0badf00d 00000000 0
04 2 00000114 00000000 0badf00d 0
04 4 a0000111 00000000 000000be 0
04 1 a0000112 00000000 ffffdead 0
00 0 00000000 00000000 00000000 0
05 a 00000118 01020304 00000000 0
05 2 00000119 00000000 00000000 1
05 9 00000119 0000ffff 00000000 1
05 a 0000011a aaaaaaaa 00000000 1
05 1 0000011b 00000000 00000000 1
05 5 00000119 00000000 00000000 1
05 2 00000118 00000000 01020304 0
00 0 00000000 00000000 00000000 0
06 2 00000100 00000000 11223344 0
06 2 00000104 00000000 cafef00d 0
06 2 00000108 00000000 77661234 0
06 2 0000010c 00000000 80ff7f01 0
06 2 a0000110 00000000 deadbeef 0
06 2 00000114 00000000 0badf00d 0
06 4 0000010f 00000000 00000080 0
06 1 0000010e 00000000 ffff80ff 0
06 2 00000118 00000000 01020304 0
ff 0 00000000 00000000 00000000 0

/* test/dbus_subsystem_properties.sv */
module dbus_subsystem_properties #(
	parameter int pipe_depth = 2
)(
	input logic clk,
	input logic rst,
	input logic dbus_read,
	input logic dbus_write,
	input logic dbus_uncached_read,
	input logic dbus_uncached_write,
	input logic misaligned,
	input logic load_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic load_issued;
	logic any_strobe;
	int   assert_errors = 0;

	assign load_issued = dbus_read || dbus_uncached_read;
	assign any_strobe  = dbus_read || dbus_write || dbus_uncached_read || dbus_uncached_write;

	strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
		$onehot0({dbus_read, dbus_write, dbus_uncached_read, dbus_uncached_write}))
		else begin
			assert_errors++;
			$error("More than one data bus strobe is high");
		end

	no_strobe_when_misaligned: assert property (@(posedge clk) disable iff (rst)
		misaligned |-> !any_strobe)
		else begin
			assert_errors++;
			$error("A misaligned request raised a bus strobe");
		end

	load_result_timing: assert property (@(posedge clk) disable iff (rst)
		load_issued |-> ##(pipe_depth-1) load_valid)
		else begin
			assert_errors++;
			$error("A load result did not arrive pipe_depth-1 cycles after its request");
		end

	// Only with a delay stage can a result be traced back to an earlier request
	generate
		if (pipe_depth > 1) begin : g_result_origin
			result_has_load: assert property (@(posedge clk) disable iff (rst)
				load_valid |-> $past(load_issued, pipe_depth - 1))
				else begin
					assert_errors++;
					$error("A load result appeared without a matching load request");
				end
		end
	endgenerate

endmodule

bind load_store_unit dbus_subsystem_properties #(
	.pipe_depth (pipe_depth)
) u_properties (
	.clk                 (clk),
	.rst                 (rst),
	.dbus_read           (dbus_read),
	.dbus_write          (dbus_write),
	.dbus_uncached_read  (dbus_uncached_read),
	.dbus_uncached_write (dbus_uncached_write),
	.misaligned          (misaligned),
	.load_valid          (load_valid)
);

/* test/dbus_subsystem_tb.sv */
module dbus_subsystem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int pipe_depth  = 2;
	localparam int max_entries = 64;
	localparam int drain_limit = 20;
	localparam logic [31:0] bubble_tag = 32'h00;
	localparam logic [31:0] end_tag    = 32'hff;

	typedef struct packed {
		logic [31:0]      tag;
		cpu_pkg::uint32_t data;
	} pending_t;

	logic             clk;
	logic             rst;
	logic             req_valid;
	cpu_pkg::mem_op_t req_op;
	cpu_pkg::uint32_t req_addr;
	cpu_pkg::uint32_t req_wdata;
	logic             load_valid;
	cpu_pkg::uint32_t load_data;
	logic             misaligned;

	logic [31:0] golden [6*max_entries]; // Six words per entry
	pending_t    expected_loads [$];
	logic        flag_pending;
	logic        flag_expected;
	logic [31:0] flag_tag;
	int          word_errors;
	int          flag_errors;
	int          assertion_errors;
	int          other_errors;

	dbus_subsystem #(
		.pipe_depth (pipe_depth),
		.mem_size   (1024)
	) u_dbus_subsystem (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.load_valid (load_valid),
		.load_data  (load_data),
		.misaligned (misaligned)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic op_is_load(cpu_pkg::mem_op_t op);
		return op inside {cpu_pkg::op_lb, cpu_pkg::op_lh, cpu_pkg::op_lw,
			cpu_pkg::op_lbu, cpu_pkg::op_lhu};
	endfunction

	task automatic check_word(input logic [31:0] tag, input cpu_pkg::uint32_t expected,
			input cpu_pkg::uint32_t actual);
		if (actual !== expected) begin
			word_errors++;
			$display("Error: test %0h load data expected %08h actual %08h", tag, expected, actual);
		end
	endtask

	task automatic check_flag(input logic [31:0] tag, input logic expected, input logic actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("Error: test %0h misaligned expected %0b actual %0b", tag, expected, actual);
		end
	endtask

	task automatic drive_idle();
		req_valid    = 1'b0;
		req_op       = cpu_pkg::op_lw;
		req_addr     = '0;
		req_wdata    = '0;
		flag_pending = 1'b0;
	endtask

	// Checks the request of the previous cycle and any load result now on the outputs
	task automatic sample_outputs();
		pending_t entry;
		if (flag_pending) begin
			check_flag(flag_tag, flag_expected, misaligned);
		end
		if (load_valid !== 1'b0) begin
			if (expected_loads.size() == 0) begin
				other_errors++;
				$display("A load result %08h appeared with no load outstanding", load_data);
			end else begin
				entry = expected_loads.pop_front();
				check_word(entry.tag, entry.data, load_data);
			end
		end
	endtask

	task automatic drive_entry(input int i);
		logic [31:0]      tag;
		cpu_pkg::mem_op_t op;
		pending_t         entry;
		tag = golden[6*i];
		op  = cpu_pkg::mem_op_t'(golden[6*i+1][3:0]);
		if (tag == bubble_tag) begin
			drive_idle();
		end else begin
			req_valid     = 1'b1;
			req_op        = op;
			req_addr      = golden[6*i+2];
			req_wdata     = golden[6*i+3];
			flag_pending  = 1'b1;
			flag_tag      = tag;
			flag_expected = golden[6*i+5][0];
			if (op_is_load(op) && !flag_expected) begin
				entry.tag  = tag;
				entry.data = golden[6*i+4];
				expected_loads.push_back(entry);
			end
		end
	endtask

	initial begin
		int count;
		int waited;
		word_errors      = 0;
		flag_errors      = 0;
		assertion_errors = 0;
		other_errors     = 0;
		rst = 1'b1;
		drive_idle();
		$readmemh("test/dbus_golden.txt", golden);
		if ($isunknown(golden[0])) begin
			other_errors++;
			$display("The golden file could not be read");
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		count = 0;
		while (count < max_entries && !$isunknown(golden[6*count]) &&
				golden[6*count] !== end_tag) begin
			@(negedge clk);
			sample_outputs();
			drive_entry(count);
			count++;
		end
		waited = 0;
		do begin
			@(negedge clk);
			sample_outputs();
			drive_idle();
			waited++;
		end while (expected_loads.size() != 0 && waited < drain_limit);
		if (expected_loads.size() != 0) begin
			other_errors++;
			$display("Timed out with %0d load results still missing", expected_loads.size());
		end
		assertion_errors = u_dbus_subsystem.u_lsu.u_properties.assert_errors;
		$display("Error counts: load data %0d, misaligned flag %0d, assertion %0d, other %0d",
			word_errors, flag_errors, assertion_errors, other_errors);
		if (word_errors + flag_errors + assertion_errors + other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
